// File: hdl/sd_spi_consts.svh
`ifndef SD_SPI_CONSTS_SVH
`define SD_SPI_CONSTS_SVH

// Start-of-block token sent by the card ahead of a read payload.
`define SD_DATA_TOKEN 8'hFE

// MOSI filler while the host only clocks, and the MISO level of an idle card.
`define SD_IDLE_BYTE 8'hFF

// Byte counts for the phases of one transaction.
`define SD_PRE_CMD_IDLE_BYTES 10
`define SD_CMD_BYTES 6
`define SD_BLOCK_BYTES 512
`define SD_CRC_BYTES 2
`define SD_EXTRA_RESP_BYTES 4

// Poll limits, counted in whole bytes.
`define SD_CMD_RESP_TIMEOUT_BYTES 255
`define SD_READ_TOKEN_TIMEOUT_BYTES 16384

// R1 value reported when the data token never shows up.
`define SD_TOKEN_TIMEOUT_CODE 8'h05

`endif

// File: hdl/sd_spi_pkg.sv
package sd_spi_pkg;

    // One byte on the SPI wires.
    typedef logic [7:0] sd_byte_t;

    // Six-byte command or response frame.
    // Byte i sits at bits 8i+7 down to 8i, so index 0 is the first byte on the wire.
    typedef logic [47:0] sd_frame_t;

    // Phases of one command transaction.
    typedef enum logic [3:0] {
        IDLE,
        PRE_IDLE,
        SEND_CMD,
        WAIT_R1,
        READ_RESP,
        WAIT_TOKEN,
        READ_DATA,
        READ_CRC,
        DONE
    } sd_seq_state_t;

endpackage

// File: hdl/sd_spi_byte_engine.sv
`timescale 1ns/1ps

module sd_spi_byte_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clk_en,
    input  logic                byte_start,
    input  sd_spi_pkg::sd_byte_t tx_byte,
    input  logic                cs_hold,
    input  logic                spi_miso,
    output logic                byte_done,
    output sd_spi_pkg::sd_byte_t rx_byte,
    output logic                spi_cs,
    output logic                spi_clk,
    output logic                spi_mosi
);

    logic                 active;
    logic                 phase;
    logic                 done_q;
    logic [2:0]           bit_cnt;
    sd_spi_pkg::sd_byte_t tx_shift;
    sd_spi_pkg::sd_byte_t rx_shift;

    // The done flag waits for the next enabled step, so the strobe never shows
    // on a frozen cycle and a new byte can start right on it.
    assign byte_done = done_q & clk_en;
    assign rx_byte   = rx_shift;

    // The start step already performs the low phase of bit 7.
    // After that, phases alternate low and high until bit 0 has been sampled.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            phase    <= 1'b0;
            done_q   <= 1'b0;
            bit_cnt  <= 3'd0;
            spi_cs   <= 1'b1;
            spi_clk  <= 1'b0;
            spi_mosi <= 1'b1;
        end else if (clk_en) begin
            done_q <= 1'b0;
            if (byte_start) begin
                active   <= 1'b1;
                phase    <= 1'b1;
                bit_cnt  <= 3'd0;
                spi_cs   <= cs_hold;
                spi_clk  <= 1'b0;
                spi_mosi <= tx_byte[7];
            end else if (active && !phase) begin
                spi_clk  <= 1'b0;
                spi_mosi <= tx_shift[7];
                phase    <= 1'b1;
            end else if (active) begin
                spi_clk <= 1'b1;
                phase   <= 1'b0;
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
            end else begin
                // Between transactions the bus parks with the clock low.
                spi_cs   <= cs_hold;
                spi_clk  <= 1'b0;
                spi_mosi <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (byte_start) begin
                tx_shift <= {tx_byte[6:0], 1'b0};
            end else if (active && !phase) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
            // MISO is taken on the same step that raises SCK.
            if (active && phase && !byte_start) begin
                rx_shift <= {rx_shift[6:0], spi_miso};
            end
        end
    end

    // The sequencer may only chain a byte on the done step, never mid-byte.
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        byte_start |-> !active)
        else $error("byte_start while a byte is still shifting");

endmodule

// File: hdl/sd_cmd_sequencer.sv
`timescale 1ns/1ps

`include "sd_spi_consts.svh"

module sd_cmd_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 start,
    input  sd_spi_pkg::sd_frame_t cmd_in,
    input  logic                 byte_done,
    input  sd_spi_pkg::sd_byte_t  rx_byte,
    output logic                 byte_start,
    output sd_spi_pkg::sd_byte_t  tx_byte,
    output logic                 cs_hold,
    output sd_spi_pkg::sd_frame_t resp,
    output logic                 resp_valid,
    output sd_spi_pkg::sd_byte_t  data_byte,
    output logic                 data_valid,
    output logic                 busy,
    output logic                 done
);

    sd_spi_pkg::sd_seq_state_t state;
    sd_spi_pkg::sd_seq_state_t next_phase;
    sd_spi_pkg::sd_frame_t     cmd_q;

    logic [14:0] cnt;
    logic        is_extra;
    logic        is_read;
    logic        accept;
    logic        idle_byte;
    logic        finish;
    logic        phase_end;
    logic        r1_hit;
    logic        token_hit;
    logic        pre_last;
    logic        cmd_last;
    logic        r1_timeout;
    logic        resp_last;
    logic        token_timeout;
    logic        data_last;
    logic        crc_last;

    assign accept    = clk_en && start && (state == sd_spi_pkg::IDLE);
    assign busy      = (state != sd_spi_pkg::IDLE);
    assign r1_hit    = (rx_byte != `SD_IDLE_BYTE);
    assign token_hit = (rx_byte == `SD_DATA_TOKEN);

    // One counter serves every phase. It restarts at zero on each phase change.
    assign pre_last      = (cnt == 15'(`SD_PRE_CMD_IDLE_BYTES - 1));
    assign cmd_last      = (cnt == 15'(`SD_CMD_BYTES - 1));
    assign r1_timeout    = (cnt == 15'(`SD_CMD_RESP_TIMEOUT_BYTES - 1));
    assign resp_last     = (cnt == 15'(`SD_EXTRA_RESP_BYTES - 1));
    assign token_timeout = (cnt == 15'(`SD_READ_TOKEN_TIMEOUT_BYTES - 1));
    assign data_last     = (cnt == 15'(`SD_BLOCK_BYTES - 1));
    assign crc_last      = (cnt == 15'(`SD_CRC_BYTES - 1));

    // Decide, on each finished byte, whether the transaction ends, moves to
    // another phase, or stays where it is.
    always_comb begin
        finish     = 1'b0;
        phase_end  = 1'b0;
        next_phase = state;
        if (byte_done) begin
            case (state)
                sd_spi_pkg::PRE_IDLE: begin
                    phase_end  = pre_last;
                    next_phase = sd_spi_pkg::SEND_CMD;
                end
                sd_spi_pkg::SEND_CMD: begin
                    phase_end  = cmd_last;
                    next_phase = sd_spi_pkg::WAIT_R1;
                end
                sd_spi_pkg::WAIT_R1: begin
                    finish     = r1_hit ? (!is_extra && !is_read) : r1_timeout;
                    phase_end  = r1_hit;
                    next_phase = is_extra ? sd_spi_pkg::READ_RESP : sd_spi_pkg::WAIT_TOKEN;
                end
                sd_spi_pkg::READ_RESP: begin
                    finish = resp_last;
                end
                sd_spi_pkg::WAIT_TOKEN: begin
                    finish     = !token_hit && token_timeout;
                    phase_end  = token_hit;
                    next_phase = sd_spi_pkg::READ_DATA;
                end
                sd_spi_pkg::READ_DATA: begin
                    phase_end  = data_last;
                    next_phase = sd_spi_pkg::READ_CRC;
                end
                sd_spi_pkg::READ_CRC: begin
                    finish = crc_last;
                end
                default: begin
                    finish = 1'b0;
                end
            endcase
        end
    end

    // Bytes run back to back: the next one starts on the done step of the last.
    assign byte_start = accept || (byte_done && !finish);

    // CS stays high for the pre-command filler and whenever no byte is starting.
    assign idle_byte = (state == sd_spi_pkg::IDLE) ||
                       ((state == sd_spi_pkg::PRE_IDLE) && !pre_last);
    assign cs_hold   = idle_byte || !byte_start;

    // The latched frame shifts down a byte per sent byte, so the next
    // command byte always sits in bits 15:8.
    assign tx_byte = ((state == sd_spi_pkg::PRE_IDLE) && pre_last)  ? cmd_q[7:0]  :
                     ((state == sd_spi_pkg::SEND_CMD) && !cmd_last) ? cmd_q[15:8] :
                     `SD_IDLE_BYTE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= sd_spi_pkg::IDLE;
            cnt      <= 15'd0;
            is_extra <= 1'b0;
            is_read  <= 1'b0;
        end else if (clk_en) begin
            case (state)
                sd_spi_pkg::IDLE: begin
                    if (start) begin
                        state    <= sd_spi_pkg::PRE_IDLE;
                        cnt      <= 15'd0;
                        is_extra <= (cmd_in[5:0] == 6'd8) || (cmd_in[5:0] == 6'd58);
                        is_read  <= (cmd_in[5:0] == 6'd17);
                    end
                end
                sd_spi_pkg::DONE: begin
                    state <= sd_spi_pkg::IDLE;
                end
                default: begin
                    if (byte_done) begin
                        cnt <= cnt + 15'd1;
                        if (finish) begin
                            state <= sd_spi_pkg::DONE;
                        end else if (phase_end) begin
                            state <= next_phase;
                            cnt   <= 15'd0;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd_in;
            resp  <= '0;
        end
        if (byte_done) begin
            case (state)
                sd_spi_pkg::SEND_CMD: begin
                    cmd_q <= cmd_q >> 8;
                end
                sd_spi_pkg::WAIT_R1: begin
                    // A poll that times out reads 0xFF, which is the code to report.
                    resp[7:0] <= rx_byte;
                end
                sd_spi_pkg::READ_RESP: begin
                    // Trailing bytes enter at the top and settle at indices 1 to 4.
                    resp[39:8] <= {rx_byte, resp[39:16]};
                end
                sd_spi_pkg::WAIT_TOKEN: begin
                    if (!token_hit && token_timeout) begin
                        resp[7:0] <= `SD_TOKEN_TIMEOUT_CODE;
                    end
                end
                sd_spi_pkg::READ_DATA: begin
                    data_byte <= rx_byte;
                end
                default: begin
                end
            endcase
        end
    end

    // Output strobes last exactly one clock, even if clk_en drops after them.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done       <= 1'b0;
            resp_valid <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            done       <= finish;
            resp_valid <= finish;
            data_valid <= byte_done && (state == sd_spi_pkg::READ_DATA);
        end
    end

    a_done_pair: assert property (@(posedge clk) disable iff (!rst_n)
        (done || resp_valid) |-> (done && resp_valid && !byte_done))
        else $error("done and resp_valid out of step");

    a_data_phase: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid |-> (is_read && ((state == sd_spi_pkg::READ_DATA) ||
                                    (state == sd_spi_pkg::READ_CRC))))
        else $error("data_valid outside the data phase");

endmodule

// File: hdl/sd_spi_controller.sv
`timescale 1ns/1ps

module sd_spi_controller (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 start,
    input  sd_spi_pkg::sd_frame_t cmd_in,
    input  logic                 spi_miso,
    output sd_spi_pkg::sd_frame_t resp,
    output logic                 resp_valid,
    output sd_spi_pkg::sd_byte_t  data_byte,
    output logic                 data_valid,
    output logic                 busy,
    output logic                 done,
    output logic                 spi_cs,
    output logic                 spi_clk,
    output logic                 spi_mosi
);

    // Byte-level handshake between the FSM and the shifter.
    logic                 byte_start;
    logic                 byte_done;
    logic                 cs_hold;
    sd_spi_pkg::sd_byte_t tx_byte;
    sd_spi_pkg::sd_byte_t rx_byte;

    sd_cmd_sequencer i_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_en     (clk_en),
        .start      (start),
        .cmd_in     (cmd_in),
        .byte_done  (byte_done),
        .rx_byte    (rx_byte),
        .byte_start (byte_start),
        .tx_byte    (tx_byte),
        .cs_hold    (cs_hold),
        .resp       (resp),
        .resp_valid (resp_valid),
        .data_byte  (data_byte),
        .data_valid (data_valid),
        .busy       (busy),
        .done       (done)
    );

    sd_spi_byte_engine i_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_en     (clk_en),
        .byte_start (byte_start),
        .tx_byte    (tx_byte),
        .cs_hold    (cs_hold),
        .spi_miso   (spi_miso),
        .byte_done  (byte_done),
        .rx_byte    (rx_byte),
        .spi_cs     (spi_cs),
        .spi_clk    (spi_clk),
        .spi_mosi   (spi_mosi)
    );

endmodule

// File: bench/sd_card_model.sv
`timescale 1ns/1ps

`include "sd_spi_consts.svh"

module sd_card_model (
    input  logic                  spi_cs,
    input  logic                  spi_clk,
    input  logic                  spi_mosi,
    input  int                    r1_delay,
    input  logic [7:0]            r1_value,
    input  logic [31:0]           trailer,
    input  int                    token_delay,
    output logic                  spi_miso,
    output int                    pre_edges,
    output sd_spi_pkg::sd_frame_t rx_frame
);

    localparam logic [31:0] lfsr_seed = 32'h7a4ae117;

    logic [7:0]  in_shift;
    logic [7:0]  out_shift;
    logic [7:0]  next_out;
    logic        load_next;
    logic [31:0] lfsr;
    int          bit_cnt;
    int          cmd_cnt;
    int          hi_edges;
    logic [7:0]  reply[$];

    assign spi_miso = out_shift[7];

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Builds every byte the card sends after the last command byte.
    task automatic queue_reply(input logic [5:0] index);
        logic [7:0] data;
        reply.delete();
        if (r1_delay >= 0) begin
            repeat (r1_delay) reply.push_back(`SD_IDLE_BYTE);
            reply.push_back(r1_value);
            if (index == 6'd8 || index == 6'd58) begin
                for (int i = 0; i < 4; i++) begin
                    reply.push_back(trailer[31 - 8 * i -: 8]);
                end
            end
            if (index == 6'd17 && token_delay >= 0) begin
                repeat (token_delay) reply.push_back(`SD_IDLE_BYTE);
                reply.push_back(`SD_DATA_TOKEN);
                repeat (`SD_BLOCK_BYTES) begin
                    data = 8'h00;
                    repeat (8) begin
                        lfsr = lfsr_step(lfsr);
                        data = {data[6:0], lfsr[0]};
                    end
                    reply.push_back(data);
                end
                // CRC bytes, which the host discards.
                reply.push_back(8'hA5);
                reply.push_back(8'h3C);
            end
        end
    endtask

    initial begin
        in_shift  = 8'h00;
        out_shift = 8'hFF;
        next_out  = 8'hFF;
        load_next = 1'b0;
        lfsr      = lfsr_seed;
        bit_cnt   = 0;
        cmd_cnt   = 0;
        hi_edges  = 0;
        pre_edges = 0;
        rx_frame  = '0;
    end

    always @(negedge spi_cs) begin
        pre_edges = hi_edges;
        hi_edges  = 0;
    end

    always @(posedge spi_cs) begin
        reply.delete();
        out_shift = 8'hFF;
        load_next = 1'b0;
        bit_cnt   = 0;
        cmd_cnt   = 0;
    end

    // MOSI is taken on the rising SCK edge, as in SPI mode 0.
    always @(posedge spi_clk) begin
        if (spi_cs) begin
            hi_edges = hi_edges + 1;
        end else begin
            in_shift = {in_shift[6:0], spi_mosi};
            bit_cnt  = bit_cnt + 1;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                if (cmd_cnt < `SD_CMD_BYTES) begin
                    rx_frame[8 * cmd_cnt +: 8] = in_shift;
                    cmd_cnt = cmd_cnt + 1;
                    if (cmd_cnt == `SD_CMD_BYTES) begin
                        queue_reply(rx_frame[5:0]);
                    end
                end
                next_out  = (reply.size() > 0) ? reply.pop_front() : `SD_IDLE_BYTE;
                load_next = 1'b1;
            end
        end
    end

    // The next MISO bit goes out on the falling edge.
    always @(negedge spi_clk) begin
        if (load_next) begin
            out_shift = next_out;
            load_next = 1'b0;
        end else begin
            out_shift = {out_shift[6:0], 1'b1};
        end
    end

endmodule

// File: bench/tb_sd_spi.sv
`timescale 1ns/1ps

`include "sd_spi_consts.svh"

module tb_sd_spi;

    localparam logic [31:0] lfsr_seed = 32'h7a4ae117;

    logic                  clk;
    logic                  rst_n;
    logic                  clk_en;
    logic                  start;
    sd_spi_pkg::sd_frame_t cmd_in;
    logic                  spi_miso;
    sd_spi_pkg::sd_frame_t resp;
    logic                  resp_valid;
    sd_spi_pkg::sd_byte_t  data_byte;
    logic                  data_valid;
    logic                  busy;
    logic                  done;
    logic                  spi_cs;
    logic                  spi_clk;
    logic                  spi_mosi;

    // What the card does for the current trace line, and what it saw.
    int                    card_r1_delay;
    logic [7:0]            card_r1;
    logic [31:0]           card_trailer;
    int                    card_token_delay;
    int                    card_pre_edges;
    sd_spi_pkg::sd_frame_t card_frame;

    sd_spi_pkg::sd_frame_t frames[$];
    int                    r1_delays[$];
    logic [7:0]            r1_values[$];
    logic [31:0]           trailers[$];
    int                    token_delays[$];
    int                    gates[$];

    logic                  gate_on;
    logic [31:0]           gate_lfsr;
    logic [31:0]           data_lfsr;
    logic [7:0]            expected_data;
    int                    done_count;
    int                    data_count;
    sd_spi_pkg::sd_frame_t resp_at_done;
    longint                limit_cycles;
    logic                  limit_ready;

    sd_spi_controller i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_en     (clk_en),
        .start      (start),
        .cmd_in     (cmd_in),
        .spi_miso   (spi_miso),
        .resp       (resp),
        .resp_valid (resp_valid),
        .data_byte  (data_byte),
        .data_valid (data_valid),
        .busy       (busy),
        .done       (done),
        .spi_cs     (spi_cs),
        .spi_clk    (spi_clk),
        .spi_mosi   (spi_mosi)
    );

    sd_card_model i_card (
        .spi_cs      (spi_cs),
        .spi_clk     (spi_clk),
        .spi_mosi    (spi_mosi),
        .r1_delay    (card_r1_delay),
        .r1_value    (card_r1),
        .trailer     (card_trailer),
        .token_delay (card_token_delay),
        .spi_miso    (spi_miso),
        .pre_edges   (card_pre_edges),
        .rx_frame    (card_frame)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            stop_with_error($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                                      name, got, expected));
        end
    endtask

    // Next block byte, eight LFSR bits taken MSB first.
    task automatic predict_byte(output logic [7:0] value);
        value = 8'h00;
        repeat (8) begin
            data_lfsr = lfsr_step(data_lfsr);
            value = {value[6:0], data_lfsr[0]};
        end
    endtask

    task automatic load_trace();
        int                    fd;
        int                    status;
        string                 line;
        sd_spi_pkg::sd_frame_t frame;
        int                    r1_delay;
        int                    token_delay;
        int                    gate;
        logic [7:0]            r1;
        logic [7:0]            t0;
        logic [7:0]            t1;
        logic [7:0]            t2;
        logic [7:0]            t3;
        fd = $fopen("bench/sd_spi_trace.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open the trace file bench/sd_spi_trace.txt");
        end
        while (!$feof(fd)) begin
            status = $fgets(line, fd);
            if (status != 0) begin
                status = $sscanf(line, "%h %d %h %h %h %h %h %d %d", frame, r1_delay,
                                 r1, t0, t1, t2, t3, token_delay, gate);
                // Comment and blank lines do not convert and are skipped.
                if (status == 9) begin
                    frames.push_back(frame);
                    r1_delays.push_back(r1_delay);
                    r1_values.push_back(r1);
                    trailers.push_back({t0, t1, t2, t3});
                    token_delays.push_back(token_delay);
                    gates.push_back(gate);
                end
            end
        end
        $fclose(fd);
        if (frames.size() == 0) begin
            stop_with_error("the trace file holds no transactions");
        end
    endtask

    // Worst-case length of one line in clock cycles, with room for gating.
    function automatic longint line_cycles(input int n);
        longint     bytes;
        logic [5:0] index;
        index = frames[n][5:0];
        bytes = `SD_PRE_CMD_IDLE_BYTES + `SD_CMD_BYTES;
        if (r1_delays[n] < 0) begin
            bytes += `SD_CMD_RESP_TIMEOUT_BYTES;
        end else begin
            bytes += r1_delays[n] + 1;
            if (index == 6'd8 || index == 6'd58) begin
                bytes += 4;
            end
            if (index == 6'd17 && token_delays[n] < 0) begin
                bytes += `SD_READ_TOKEN_TIMEOUT_BYTES;
            end else if (index == 6'd17) begin
                bytes += token_delays[n] + 1 + `SD_BLOCK_BYTES + 2;
            end
        end
        return bytes * 16 * 4 + 200;
    endfunction

    task automatic run_transaction(input int n);
        sd_spi_pkg::sd_frame_t exp_resp;
        logic [5:0]            index;
        logic [31:0]           t;
        int                    exp_data;
        index    = frames[n][5:0];
        t        = trailers[n];
        exp_resp = '0;
        exp_data = 0;
        if (r1_delays[n] < 0) begin
            exp_resp[7:0] = 8'hFF;
        end else begin
            exp_resp[7:0] = r1_values[n];
            if (index == 6'd8 || index == 6'd58) begin
                // The first trailing byte lands at index 1.
                exp_resp[39:8] = {t[7:0], t[15:8], t[23:16], t[31:24]};
            end
            if (index == 6'd17 && token_delays[n] < 0) begin
                exp_resp[7:0] = 8'h05;
            end else if (index == 6'd17) begin
                exp_data = `SD_BLOCK_BYTES;
            end
        end

        @(posedge clk);
        #2;
        card_r1_delay    = r1_delays[n];
        card_r1          = r1_values[n];
        card_trailer     = t;
        card_token_delay = token_delays[n];
        gate_on          = (gates[n] != 0);
        done_count       = 0;
        data_count       = 0;
        cmd_in           = frames[n];
        start            = 1'b1;
        // Start is only taken on an enabled cycle, so hold it until busy shows.
        @(posedge clk);
        #2;
        while (!busy) begin
            @(posedge clk);
            #2;
        end
        start = 1'b0;
        while (busy) begin
            @(posedge clk);
            #2;
        end

        check_value("done pulse count", done_count, 1);
        check_value("resp", resp_at_done, exp_resp);
        check_value("data_valid pulse count", data_count, exp_data);
        check_value("card pre-command SCK edges", card_pre_edges,
                    `SD_PRE_CMD_IDLE_BYTES * 8);
        check_value("card command frame", card_frame, frames[n]);
    endtask

    always @(posedge clk) begin
        #2;
        if (gate_on) begin
            gate_lfsr = lfsr_step(gate_lfsr);
            clk_en = gate_lfsr[0];
        end else begin
            clk_en = 1'b1;
        end
    end

    // Registered outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (done || resp_valid) begin
                // Both strobes mark the end of the transaction on the same cycle.
                check_value("done", done, 1);
                check_value("resp_valid", resp_valid, 1);
                done_count   = done_count + 1;
                resp_at_done = resp;
            end
            if (data_valid) begin
                predict_byte(expected_data);
                check_value("data_byte", data_byte, expected_data);
                data_count = data_count + 1;
            end
        end
    end

    initial begin
        wait (limit_ready);
        repeat (limit_cycles) @(posedge clk);
        stop_with_error("watchdog expired before all trace lines completed");
    end

    initial begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        clk_en           = 1'b1;
        start            = 1'b0;
        cmd_in           = '0;
        gate_on          = 1'b0;
        gate_lfsr        = lfsr_seed;
        data_lfsr        = lfsr_seed;
        done_count       = 0;
        data_count       = 0;
        limit_ready      = 1'b0;
        card_r1_delay    = -1;
        card_r1          = 8'hFF;
        card_trailer     = '0;
        card_token_delay = -1;

        load_trace();
        limit_cycles = 200;
        foreach (frames[i]) begin
            limit_cycles += line_cycles(i);
        end
        limit_ready = 1'b1;

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("spi_cs", spi_cs, 1);
        check_value("spi_clk", spi_clk, 0);
        check_value("spi_mosi", spi_mosi, 1);
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("resp_valid", resp_valid, 0);
        check_value("data_valid", data_valid, 0);

        foreach (frames[i]) begin
            run_transaction(i);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/sd_spi_pkg.sv
hdl/sd_spi_byte_engine.sv
hdl/sd_cmd_sequencer.sv
hdl/sd_spi_controller.sv
bench/sd_card_model.sv
bench/tb_sd_spi.sv

// File: bench/sd_spi_trace.txt
# frame(hex, byte 0 in the low bits) r1_delay r1 trail0 trail1 trail2 trail3 token_delay gate
# A delay of -1 means the card never sends that byte. Gate 1 drives clk_en from the LFSR.
950000000040 0 01 00 00 00 00 -1 0
950000000040 4 01 00 00 00 00 -1 1
87aa01000048 1 01 00 00 01 aa -1 0
fd000000007a 2 00 c0 ff 80 00 -1 1
950000000040 -1 00 00 00 00 00 -1 0
ff0002000051 1 00 00 00 00 00 5 0
ff0004000051 0 00 00 00 00 00 30 1
ff0006000051 2 00 00 00 00 00 -1 0
